//--- include/rs_ldst_ref.svh
`ifndef RS_LDST_REF_SVH
`define RS_LDST_REF_SVH

// mirrored station state, one slot per entry
logic      m_busy    [ENT_NUM];
logic      m_spec    [ENT_NUM];
logic      m_written [ENT_NUM]; // fields hold a known value
data_t     m_src1    [ENT_NUM];
data_t     m_src2    [ENT_NUM];
logic      m_v1      [ENT_NUM];
logic      m_v2      [ENT_NUM];
data_t     m_imm     [ENT_NUM];
rrf_tag_t  m_rrftag  [ENT_NUM];
spec_tag_t m_spectag [ENT_NUM];

// true when a live, unkilled bus carries the operand's tag
function automatic logic bus_hit(data_t opr);
   logic hit;
   hit = 1'b0;
   for (int b = 0; b < WB_NUM; b++) begin
      if (exvalid[b] && !kill_spec[b] && exdst[b] == opr[RRF_SEL-1:0]) begin
         hit = 1'b1;
      end
   end
   return hit;
endfunction

function automatic data_t operand_value(data_t opr, logic valid);
   data_t val;
   val = opr;
   for (int b = 0; b < WB_NUM; b++) begin
      if (!valid && exvalid[b] && !kill_spec[b] && exdst[b] == opr[RRF_SEL-1:0]) begin
         val = exrslt[b];
      end
   end
   return val;
endfunction

function automatic logic [ENT_NUM-1:0] busy_vector();
   logic [ENT_NUM-1:0] vec;
   for (int i = 0; i < ENT_NUM; i++) begin
      vec[i] = m_busy[i];
   end
   return vec;
endfunction

function automatic logic [ENT_NUM-1:0] ready_vector();
   logic [ENT_NUM-1:0] vec;
   for (int i = 0; i < ENT_NUM; i++) begin
      vec[i] = m_busy[i] && m_v1[i] && m_v2[i];
   end
   return vec;
endfunction

// entries left busy if a miss hits this cycle
function automatic logic [ENT_NUM-1:0] miss_survivors();
   logic [ENT_NUM-1:0] vec;
   for (int i = 0; i < ENT_NUM; i++) begin
      vec[i] = m_busy[i] && ((m_spectag[i] & specfixtag) == '0);
   end
   return vec;
endfunction

function automatic logic issue_specbit();
   if (prsuccess) begin
      return m_spec[issueaddr] && (m_spectag[issueaddr] != prtag);
   end
   return m_spec[issueaddr];
endfunction

task automatic model_reset();
   for (int i = 0; i < ENT_NUM; i++) begin
      m_busy[i]    = 1'b0;
      m_spec[i]    = 1'b0;
      m_written[i] = 1'b0;
      m_v1[i]      = 1'b0;
      m_v2[i]      = 1'b0;
      m_spectag[i] = '0;
   end
endtask

// state after the coming edge, from the inputs held now
task automatic advance_model();
   logic accept;
   logic h1;
   logic h2;
   accept = alloc && !prmiss && !prsuccess;
   for (int i = 0; i < ENT_NUM; i++) begin
      if (prmiss) begin
         m_busy[i] = m_busy[i] && ((m_spectag[i] & specfixtag) == '0);
         m_spec[i] = 1'b0;
      end else if (prsuccess && m_spectag[i] == prtag) begin
         m_spec[i] = 1'b0;
      end
      if (!prmiss && clearbusy && i == int'(issueaddr)) begin
         m_busy[i] = 1'b0;
      end
      if (accept && i == int'(waddr)) begin
         m_busy[i]    = 1'b1;
         m_spec[i]    = wspecbit;
         m_written[i] = 1'b1;
         m_src1[i]    = wsrc1;
         m_src2[i]    = wsrc2;
         m_v1[i]      = wvalid1;
         m_v2[i]      = wvalid2;
         m_imm[i]     = wimm;
         m_rrftag[i]  = wrrftag;
         m_spectag[i] = wspectag;
      end else begin
         h1 = bus_hit(m_src1[i]);
         h2 = bus_hit(m_src2[i]);
         m_src1[i] = operand_value(m_src1[i], m_v1[i]);
         m_src2[i] = operand_value(m_src2[i], m_v2[i]);
         m_v1[i]   = m_v1[i] || h1;
         m_v2[i]   = m_v2[i] || h2;
      end
   end
endtask

`endif

//--- dv/rs_ldst_tb.sv
`timescale 1ns/1ps
module rs_ldst_tb;
   import rs_cfg_pkg::*;
   import rs_spec_pkg::*;

   localparam int ENT_NUM         = 4;
   localparam int WB_NUM          = 3;
   localparam int ENT_SEL         = 2;
   localparam int RESET_CYCLES    = 8;
   localparam int DIRECTED_CYCLES = 40; // upper bound of the directed part
   localparam int RAND_CYCLES     = 400;
   localparam int CYCLE_LIMIT     = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES);

   logic                    clk;
   logic                    reset;
   logic                    alloc;
   logic      [ENT_SEL-1:0] waddr;
   data_t                   wsrc1;
   data_t                   wsrc2;
   logic                    wvalid1;
   logic                    wvalid2;
   data_t                   wimm;
   rrf_tag_t                wrrftag;
   spec_tag_t               wspectag;
   logic                    wspecbit;
   logic                    clearbusy;
   logic      [ENT_SEL-1:0] issueaddr;
   logic                    prmiss;
   logic                    prsuccess;
   spec_tag_t               prtag;
   spec_tag_t               specfixtag;
   data_t     [WB_NUM-1:0]  exrslt;
   rrf_tag_t  [WB_NUM-1:0]  exdst;
   logic      [WB_NUM-1:0]  exvalid;
   logic      [WB_NUM-1:0]  kill_spec;
   logic      [ENT_NUM-1:0] busyvec;
   logic      [ENT_NUM-1:0] prbusyvec_next;
   logic      [ENT_NUM-1:0] ready;
   data_t                   ex_src1;
   data_t                   ex_src2;
   data_t                   imm;
   rrf_tag_t                rrftag;
   spec_tag_t               spectag;
   logic                    specbit;
   integer                  seed;
   int                      cycles;

   rs_ldst_top #(.ENT_NUM(ENT_NUM), .WB_NUM(WB_NUM)) u_dut (
      .clk            (clk),
      .reset          (reset),
      .alloc          (alloc),
      .waddr          (waddr),
      .wsrc1          (wsrc1),
      .wsrc2          (wsrc2),
      .wvalid1        (wvalid1),
      .wvalid2        (wvalid2),
      .wimm           (wimm),
      .wrrftag        (wrrftag),
      .wspectag       (wspectag),
      .wspecbit       (wspecbit),
      .clearbusy      (clearbusy),
      .issueaddr      (issueaddr),
      .prmiss         (prmiss),
      .prsuccess      (prsuccess),
      .prtag          (prtag),
      .specfixtag     (specfixtag),
      .exrslt         (exrslt),
      .exdst          (exdst),
      .exvalid        (exvalid),
      .kill_spec      (kill_spec),
      .busyvec        (busyvec),
      .prbusyvec_next (prbusyvec_next),
      .ready          (ready),
      .ex_src1        (ex_src1),
      .ex_src2        (ex_src2),
      .imm            (imm),
      .rrftag         (rrftag),
      .spectag        (spectag),
      .specbit        (specbit)
   );

   `include "rs_ldst_ref.svh"

   task automatic report_fail(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_tag(input string name, input rrf_tag_t got, input rrf_tag_t exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_spec(input string name, input spec_tag_t got, input spec_tag_t exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_vec(input string name, input logic [ENT_NUM-1:0] got,
                            input logic [ENT_NUM-1:0] exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic compare_outputs();
      check_vec("busyvec", busyvec, busy_vector());
      check_vec("prbusyvec_next", prbusyvec_next, miss_survivors());
      check_vec("ready", ready, ready_vector());
      check_spec("spectag", spectag, m_spectag[issueaddr]);
      check_bit("specbit", specbit, issue_specbit());
      if (m_written[issueaddr]) begin
         check_data("ex_src1", ex_src1, operand_value(m_src1[issueaddr], m_v1[issueaddr]));
         check_data("ex_src2", ex_src2, operand_value(m_src2[issueaddr], m_v2[issueaddr]));
         check_data("imm", imm, m_imm[issueaddr]);
         check_tag("rrftag", rrftag, m_rrftag[issueaddr]);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic settle();
      #15;
   endtask

   task automatic clear_strobes();
      alloc     = 1'b0;
      clearbusy = 1'b0;
      prmiss    = 1'b0;
      prsuccess = 1'b0;
      exvalid   = '0;
      kill_spec = '0;
   endtask

   task automatic alloc_entry(input int addr, input data_t s1, input logic v1,
                              input data_t s2, input logic v2, input data_t imm_val,
                              input rrf_tag_t tag, input spec_tag_t stag, input logic sbit);
      alloc    = 1'b1;
      waddr    = addr[ENT_SEL-1:0];
      wsrc1    = s1;
      wvalid1  = v1;
      wsrc2    = s2;
      wvalid2  = v2;
      wimm     = imm_val;
      wrrftag  = tag;
      wspectag = stag;
      wspecbit = sbit;
   endtask

   task automatic broadcast(input int bus, input rrf_tag_t tag, input data_t value,
                            input logic kill);
      exvalid[bus]   = 1'b1;
      exdst[bus]     = tag;
      exrslt[bus]    = value;
      kill_spec[bus] = kill;
   endtask

   function automatic spec_tag_t one_hot(int k);
      return spec_tag_t'(1) << (k % SPECTAG_LEN);
   endfunction

   function automatic int free_slot(int start);
      int idx;
      for (int i = 0; i < ENT_NUM; i++) begin
         idx = (start + i) % ENT_NUM;
         if (!m_busy[idx]) begin
            return idx;
         end
      end
      return -1;
   endfunction

   task automatic random_cycle();
      int r;
      int slot;
      clear_strobes();
      r = $random(seed);
      issueaddr = r[1:0];
      if (r[6:2] == 5'd0) begin
         prmiss     = 1'b1;
         specfixtag = r[11:7];
      end else if (r[6:2] == 5'd1) begin
         prsuccess = 1'b1;
         prtag     = one_hot(int'(r[11:7]));
      end
      if (m_busy[issueaddr] && r[12]) begin
         clearbusy = 1'b1; // scheduler only frees held entries
      end
      slot = free_slot(int'(r[14:13]));
      if (slot >= 0 && r[15]) begin
         alloc_entry(slot, $random(seed), r[16], $random(seed), r[17], $random(seed),
                     rrf_tag_t'(r[23:18]), one_hot(int'(r[28:24])), r[29]);
         r = $random(seed);
         if (!wvalid1) begin
            wsrc1[RRF_SEL-1:0] = rrf_tag_t'(r[2:0]); // tag the buses reach
         end
         if (!wvalid2) begin
            wsrc2[RRF_SEL-1:0] = rrf_tag_t'(r[5:3]);
         end
      end
      r = $random(seed);
      for (int b = 0; b < WB_NUM; b++) begin
         exvalid[b]   = r[3 + b];
         kill_spec[b] = r[6 + b] & r[9 + b];
         exdst[b]     = rrf_tag_t'(int'(r[2:0]) + b); // distinct per bus
         exrslt[b]    = $random(seed);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > CYCLE_LIMIT) begin
            report_fail($sformatf("timeout: run did not finish in %0d cycles", CYCLE_LIMIT));
         end
      end
   end

   // compare just before each rising edge and step the model
   initial begin
      forever begin
         @(posedge clk);
         #19;
         if (reset) begin
            model_reset();
         end else begin
            compare_outputs();
            advance_model();
         end
      end
   end

   initial begin
      seed       = 83;
      reset      = 1'b1;
      waddr      = '0;
      wsrc1      = '0;
      wsrc2      = '0;
      wvalid1    = 1'b0;
      wvalid2    = 1'b0;
      wimm       = '0;
      wrrftag    = '0;
      wspectag   = '0;
      wspecbit   = 1'b0;
      issueaddr  = '0;
      prtag      = '0;
      specfixtag = '0;
      exrslt     = '0;
      exdst      = '0;
      clear_strobes();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      // both operands valid so ready after one edge
      alloc_entry(0, 32'h1111_0000, 1'b1, 32'h2222_0000, 1'b1, 32'h40, 6'h21, 5'b00001, 1'b1);
      next_cycle();
      clear_strobes();
      settle();
      check_vec("ready", ready, 4'b0001);
      check_data("ex_src2", ex_src2, 32'h2222_0000);
      next_cycle();

      // pending src1 waits on tag 0a
      alloc_entry(1, 32'h0000_000a, 1'b0, 32'h33, 1'b1, 32'h08, 6'h05, 5'b00010, 1'b1);
      issueaddr = 2'd1;
      next_cycle();
      clear_strobes();
      broadcast(0, 6'h0a, 32'hdead_0001, 1'b1);
      next_cycle();
      clear_strobes();
      broadcast(1, 6'h0a, 32'hdead_0002, 1'b0);
      exvalid[1] = 1'b0;
      next_cycle();
      clear_strobes();
      broadcast(2, 6'h0a, 32'hcafe_0002, 1'b0);
      broadcast(0, 6'h11, 32'hbeef_0003, 1'b0);
      settle();
      check_data("ex_src1", ex_src1, 32'hcafe_0002);
      check_vec("ready", ready, 4'b0001);
      next_cycle();
      clear_strobes();
      settle();
      check_vec("ready", ready, 4'b0011);
      next_cycle();

      // free entry 0 and refill it
      issueaddr = 2'd0;
      clearbusy = 1'b1;
      next_cycle();
      clear_strobes();
      settle();
      check_vec("busyvec", busyvec, 4'b0010);
      next_cycle();
      alloc_entry(0, 32'h5555_0000, 1'b1, 32'h6666_0000, 1'b1, 32'h7f, 6'h2a, 5'b00100, 1'b1);
      next_cycle();
      clear_strobes();
      settle();
      check_data("imm", imm, 32'h7f);
      check_tag("rrftag", rrftag, 6'h2a);
      next_cycle();

      // miss kills entries under the fix mask
      alloc_entry(2, 32'h77, 1'b1, 32'h88, 1'b1, 32'h10, 6'h12, 5'b01000, 1'b1);
      next_cycle();
      alloc_entry(3, 32'h99, 1'b1, 32'haa, 1'b1, 32'h14, 6'h13, 5'b10000, 1'b0);
      next_cycle();
      clear_strobes();
      prmiss     = 1'b1;
      specfixtag = 5'b01100;
      alloc_entry(0, 32'hffff_ffff, 1'b1, 32'hffff_ffff, 1'b1, 32'h1, 6'h3f, 5'b00001, 1'b1);
      settle();
      check_vec("prbusyvec_next", prbusyvec_next, 4'b1010);
      next_cycle();
      clear_strobes();
      settle();
      check_vec("busyvec", busyvec, 4'b1010);
      check_data("imm", imm, 32'h7f); // entry 0 kept its old fields
      check_spec("spectag", spectag, 5'b00100);
      next_cycle();

      // success drops matching spec bits
      alloc_entry(0, 32'h1234, 1'b1, 32'h5678, 1'b1, 32'h20, 6'h01, 5'b00001, 1'b1);
      next_cycle();
      alloc_entry(2, 32'h4321, 1'b1, 32'h8765, 1'b1, 32'h24, 6'h02, 5'b00010, 1'b1);
      next_cycle();
      clear_strobes();
      prsuccess = 1'b1;
      prtag     = 5'b00010;
      issueaddr = 2'd2;
      settle();
      check_bit("specbit", specbit, 1'b0);
      next_cycle();
      clear_strobes();
      issueaddr = 2'd0;
      settle();
      check_bit("specbit", specbit, 1'b1);
      next_cycle();

      for (int n = 0; n < RAND_CYCLES; n++) begin
         random_cycle();
         next_cycle();
      end
      clear_strobes();
      repeat (2) next_cycle();

      $display("all tests passed");
      $finish;
   end

endmodule

//--- hw/rs_busy_ctrl.sv
`timescale 1ns/1ps
module rs_busy_ctrl #(
   parameter int  ENT_NUM = 4,
   localparam int ENT_SEL = (ENT_NUM > 1) ? $clog2(ENT_NUM) : 1
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  alloc,
   input  logic                   [ENT_SEL-1:0]  waddr,
   input  logic                                  wspecbit,
   input  logic                                  clearbusy,
   input  logic                   [ENT_SEL-1:0]  issueaddr,
   input  logic                                  prmiss,
   input  logic                                  prsuccess,
   input  rs_spec_pkg::spec_tag_t                prtag,
   input  rs_spec_pkg::spec_tag_t                specfixtag,
   input  rs_spec_pkg::spec_tag_t [ENT_NUM-1:0]  ent_spectag,
   output logic                   [ENT_NUM-1:0]  busyvec,
   output logic                   [ENT_NUM-1:0]  specbitvec_next,
   output logic                   [ENT_NUM-1:0]  specbitvec,
   output logic                   [ENT_NUM-1:0]  prbusyvec_next,
   output logic                   [ENT_NUM-1:0]  ent_we
);

   logic accept;

   // branch events take the cycle, allocation waits
   assign accept = alloc & ~prmiss & ~prsuccess;

   always_comb begin
      for (int i = 0; i < ENT_NUM; i++) begin
         // survives a miss only if no tag bit falls under the fix mask
         prbusyvec_next[i]  = busyvec[i] & ~(|(ent_spectag[i] & specfixtag));
         specbitvec_next[i] = specbitvec[i] & (ent_spectag[i] != prtag);
      end
   end

   always_comb begin
      ent_we = '0;
      if (accept) begin
         ent_we[waddr] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busyvec    <= '0;
         specbitvec <= '0;
      end else if (prmiss) begin
         busyvec    <= prbusyvec_next; // clearbusy dropped here
         specbitvec <= '0;
      end else begin
         if (prsuccess) begin
            specbitvec <= specbitvec_next;
         end
         if (accept) begin
            busyvec[waddr]    <= 1'b1;
            specbitvec[waddr] <= wspecbit;
         end
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
      end
   end

   // the allocator hands out free slots only
   a_alloc_free: assert property (
      @(posedge clk) disable iff (reset)
      accept |-> !busyvec[waddr]
   ) else $error("rs_busy_ctrl: allocation into busy entry %0d", waddr);

   // the scheduler only issues entries that hold an op
   a_clear_busy: assert property (
      @(posedge clk) disable iff (reset)
      clearbusy |-> busyvec[issueaddr]
   ) else $error("rs_busy_ctrl: clearbusy on idle entry %0d", issueaddr);

endmodule

//--- hw/rs_cfg_pkg.sv
package rs_cfg_pkg;

   // operand and immediate width
   parameter int DATA_LEN = 32;

   // rename register tag width
   parameter int RRF_SEL = 6;

   // operand or immediate word
   // a pending operand keeps its producer tag in the low RRF_SEL bits
   typedef logic [DATA_LEN-1:0] data_t;

   // rename register tag
   typedef logic [RRF_SEL-1:0] rrf_tag_t;

endpackage

//--- hw/rs_issue_sel.sv
`timescale 1ns/1ps
module rs_issue_sel #(
   parameter int  ENT_NUM = 4,
   localparam int ENT_SEL = (ENT_NUM > 1) ? $clog2(ENT_NUM) : 1
) (
   input  logic                   [ENT_SEL-1:0] issueaddr,
   input  logic                                 prsuccess,
   input  logic                   [ENT_NUM-1:0] specbitvec,
   input  logic                   [ENT_NUM-1:0] specbitvec_next,
   input  rs_cfg_pkg::data_t      [ENT_NUM-1:0] ent_ex_src1,
   input  rs_cfg_pkg::data_t      [ENT_NUM-1:0] ent_ex_src2,
   input  rs_cfg_pkg::data_t      [ENT_NUM-1:0] ent_imm,
   input  rs_cfg_pkg::rrf_tag_t   [ENT_NUM-1:0] ent_rrftag,
   input  rs_spec_pkg::spec_tag_t [ENT_NUM-1:0] ent_spectag,
   output rs_cfg_pkg::data_t                    ex_src1,
   output rs_cfg_pkg::data_t                    ex_src2,
   output rs_cfg_pkg::data_t                    imm,
   output rs_cfg_pkg::rrf_tag_t                 rrftag,
   output rs_spec_pkg::spec_tag_t               spectag,
   output logic                                 specbit
);

   assign ex_src1 = ent_ex_src1[issueaddr]; // already bypassed in the entry
   assign ex_src2 = ent_ex_src2[issueaddr];
   assign imm     = ent_imm[issueaddr];
   assign rrftag  = ent_rrftag[issueaddr];
   assign spectag = ent_spectag[issueaddr];

   // a resolving branch drops the spec bit right away
   assign specbit = prsuccess ? specbitvec_next[issueaddr] : specbitvec[issueaddr];

endmodule

//--- hw/rs_ldst_ent.sv
`timescale 1ns/1ps
module rs_ldst_ent #(
   parameter int WB_NUM = 3
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              busy,
   input  logic                              we,
   input  rs_cfg_pkg::data_t                 wsrc1,
   input  rs_cfg_pkg::data_t                 wsrc2,
   input  logic                              wvalid1,
   input  logic                              wvalid2,
   input  rs_cfg_pkg::data_t                 wimm,
   input  rs_cfg_pkg::rrf_tag_t              wrrftag,
   input  rs_spec_pkg::spec_tag_t            wspectag,
   input  rs_cfg_pkg::data_t    [WB_NUM-1:0] exrslt,
   input  rs_cfg_pkg::rrf_tag_t [WB_NUM-1:0] exdst,
   input  logic                 [WB_NUM-1:0] exvalid,
   input  logic                 [WB_NUM-1:0] kill_spec,
   output rs_cfg_pkg::data_t                 ex_src1,
   output rs_cfg_pkg::data_t                 ex_src2,
   output logic                              ready,
   output rs_cfg_pkg::data_t                 imm,
   output rs_cfg_pkg::rrf_tag_t              rrftag,
   output rs_spec_pkg::spec_tag_t            spectag
);
   import rs_cfg_pkg::*;

   data_t src1;
   data_t src2;
   logic  valid1;
   logic  valid2;
   data_t nextsrc1;
   data_t nextsrc2;
   logic  nextvalid1;
   logic  nextvalid2;

   assign ready = busy & valid1 & valid2;

   // wakeup result already folded in, so a same-cycle broadcast is bypassed
   assign ex_src1 = nextsrc1;
   assign ex_src2 = nextsrc2;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid1  <= 1'b0;
         valid2  <= 1'b0;
         spectag <= '0;
      end else if (we) begin
         valid1  <= wvalid1;
         valid2  <= wvalid2;
         spectag <= wspectag;
      end else begin
         valid1 <= nextvalid1;
         valid2 <= nextvalid2;
      end
   end

   always_ff @(posedge clk) begin
      if (we) begin
         src1   <= wsrc1;
         src2   <= wsrc2;
         imm    <= wimm;
         rrftag <= wrrftag;
      end else begin
         src1 <= nextsrc1; // captures a broadcast value
         src2 <= nextsrc2;
      end
   end

   src_wakeup #(.WB_NUM(WB_NUM)) u_wake1 (
      .opr       (src1),
      .opr_rdy   (valid1),
      .exrslt    (exrslt),
      .exdst     (exdst),
      .exvalid   (exvalid),
      .kill_spec (kill_spec),
      .src       (nextsrc1),
      .resolved  (nextvalid1)
   );

   src_wakeup #(.WB_NUM(WB_NUM)) u_wake2 (
      .opr       (src2),
      .opr_rdy   (valid2),
      .exrslt    (exrslt),
      .exdst     (exdst),
      .exvalid   (exvalid),
      .kill_spec (kill_spec),
      .src       (nextsrc2),
      .resolved  (nextvalid2)
   );

endmodule

//--- hw/rs_ldst_top.sv
`timescale 1ns/1ps
module rs_ldst_top #(
   parameter int  ENT_NUM = 4,
   parameter int  WB_NUM  = 3,
   localparam int ENT_SEL = (ENT_NUM > 1) ? $clog2(ENT_NUM) : 1
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              alloc,
   input  logic                 [ENT_SEL-1:0] waddr,
   input  rs_cfg_pkg::data_t                 wsrc1,
   input  rs_cfg_pkg::data_t                 wsrc2,
   input  logic                              wvalid1,
   input  logic                              wvalid2,
   input  rs_cfg_pkg::data_t                 wimm,
   input  rs_cfg_pkg::rrf_tag_t              wrrftag,
   input  rs_spec_pkg::spec_tag_t            wspectag,
   input  logic                              wspecbit,
   input  logic                              clearbusy,
   input  logic                 [ENT_SEL-1:0] issueaddr,
   input  logic                              prmiss,
   input  logic                              prsuccess,
   input  rs_spec_pkg::spec_tag_t            prtag,
   input  rs_spec_pkg::spec_tag_t            specfixtag,
   input  rs_cfg_pkg::data_t    [WB_NUM-1:0] exrslt,
   input  rs_cfg_pkg::rrf_tag_t [WB_NUM-1:0] exdst,
   input  logic                 [WB_NUM-1:0] exvalid,
   input  logic                 [WB_NUM-1:0] kill_spec,
   output logic                 [ENT_NUM-1:0] busyvec,
   output logic                 [ENT_NUM-1:0] prbusyvec_next,
   output logic                 [ENT_NUM-1:0] ready,
   output rs_cfg_pkg::data_t                 ex_src1,
   output rs_cfg_pkg::data_t                 ex_src2,
   output rs_cfg_pkg::data_t                 imm,
   output rs_cfg_pkg::rrf_tag_t              rrftag,
   output rs_spec_pkg::spec_tag_t            spectag,
   output logic                              specbit
);
   import rs_cfg_pkg::*;
   import rs_spec_pkg::*;

   logic      [ENT_NUM-1:0] ent_we;
   logic      [ENT_NUM-1:0] specbitvec;
   logic      [ENT_NUM-1:0] specbitvec_next;
   data_t     [ENT_NUM-1:0] ent_ex_src1;
   data_t     [ENT_NUM-1:0] ent_ex_src2;
   data_t     [ENT_NUM-1:0] ent_imm;
   rrf_tag_t  [ENT_NUM-1:0] ent_rrftag;
   spec_tag_t [ENT_NUM-1:0] ent_spectag;

   rs_busy_ctrl #(.ENT_NUM(ENT_NUM)) u_busy_ctrl (
      .clk             (clk),
      .reset           (reset),
      .alloc           (alloc),
      .waddr           (waddr),
      .wspecbit        (wspecbit),
      .clearbusy       (clearbusy),
      .issueaddr       (issueaddr),
      .prmiss          (prmiss),
      .prsuccess       (prsuccess),
      .prtag           (prtag),
      .specfixtag      (specfixtag),
      .ent_spectag     (ent_spectag),
      .busyvec         (busyvec),
      .specbitvec_next (specbitvec_next),
      .specbitvec      (specbitvec),
      .prbusyvec_next  (prbusyvec_next),
      .ent_we          (ent_we)
   );

   for (genvar i = 0; i < ENT_NUM; i++) begin : g_ent
      rs_ldst_ent #(.WB_NUM(WB_NUM)) u_ent (
         .clk       (clk),
         .reset     (reset),
         .busy      (busyvec[i]),
         .we        (ent_we[i]),
         .wsrc1     (wsrc1),
         .wsrc2     (wsrc2),
         .wvalid1   (wvalid1),
         .wvalid2   (wvalid2),
         .wimm      (wimm),
         .wrrftag   (wrrftag),
         .wspectag  (wspectag),
         .exrslt    (exrslt),
         .exdst     (exdst),
         .exvalid   (exvalid),
         .kill_spec (kill_spec),
         .ex_src1   (ent_ex_src1[i]),
         .ex_src2   (ent_ex_src2[i]),
         .ready     (ready[i]),
         .imm       (ent_imm[i]),
         .rrftag    (ent_rrftag[i]),
         .spectag   (ent_spectag[i])
      );
   end

   rs_issue_sel #(.ENT_NUM(ENT_NUM)) u_issue_sel (
      .issueaddr       (issueaddr),
      .prsuccess       (prsuccess),
      .specbitvec      (specbitvec),
      .specbitvec_next (specbitvec_next),
      .ent_ex_src1     (ent_ex_src1),
      .ent_ex_src2     (ent_ex_src2),
      .ent_imm         (ent_imm),
      .ent_rrftag      (ent_rrftag),
      .ent_spectag     (ent_spectag),
      .ex_src1         (ex_src1),
      .ex_src2         (ex_src2),
      .imm             (imm),
      .rrftag          (rrftag),
      .spectag         (spectag),
      .specbit         (specbit)
   );

endmodule

//--- hw/rs_spec_pkg.sv
package rs_spec_pkg;

   // one bit per outstanding branch
   parameter int SPECTAG_LEN = 5;

   // one-hot speculation tag, or a mask of several tags on a fix
   typedef logic [SPECTAG_LEN-1:0] spec_tag_t;

endpackage

//--- hw/src_wakeup.sv
`timescale 1ns/1ps
module src_wakeup #(
   parameter int WB_NUM = 3
) (
   input  rs_cfg_pkg::data_t                opr,
   input  logic                             opr_rdy,
   input  rs_cfg_pkg::data_t   [WB_NUM-1:0] exrslt,
   input  rs_cfg_pkg::rrf_tag_t [WB_NUM-1:0] exdst,
   input  logic                [WB_NUM-1:0] exvalid,
   input  logic                [WB_NUM-1:0] kill_spec,
   output rs_cfg_pkg::data_t                src,
   output logic                             resolved
);
   import rs_cfg_pkg::*;

   rrf_tag_t          opr_tag;
   logic [WB_NUM-1:0] hit;
   data_t             hit_rslt;

   assign opr_tag = opr[RRF_SEL-1:0]; // producer tag while pending

   always_comb begin
      hit = '0;
      hit_rslt = '0;
      for (int i = 0; i < WB_NUM; i++) begin
         hit[i] = exvalid[i] & ~kill_spec[i] & (exdst[i] == opr_tag);
         if (hit[i]) begin
            hit_rslt = exrslt[i];
         end
      end
   end

   assign resolved = opr_rdy | (|hit);
   assign src      = (!opr_rdy && (|hit)) ? hit_rslt : opr;

   // a rename tag is written back by a single bus in a given cycle
   always_comb begin
      if (!opr_rdy) begin
         a_one_match: assert ($onehot0(hit))
            else $error("src_wakeup: tag %0h matched on several buses", opr_tag);
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module rs_ldst_tb -o sim_rs_ldst
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_rs_ldst > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "RESULT: PASS"
exit 0

//--- sources.f
hw/rs_cfg_pkg.sv
hw/rs_spec_pkg.sv
+incdir+include
hw/src_wakeup.sv
hw/rs_ldst_ent.sv
hw/rs_busy_ctrl.sv
hw/rs_issue_sel.sv
hw/rs_ldst_top.sv
dv/rs_ldst_tb.sv
